/* design/key_pkg.sv */
`default_nettype none

package key_pkg;

	// one decoded key press, valid is a single-cycle strobe
	typedef struct packed {
		logic       valid;
		logic [7:0] code;
	} key_event_t;

	// ========================================
	// scan codes
	localparam logic [7:0] key_start      = 8'h5A;
	localparam logic [7:0] key_left       = 8'h6B;
	localparam logic [7:0] key_right      = 8'h74;
	localparam logic [7:0] key_rot_cw     = 8'h12;  // rotation + 1
	localparam logic [7:0] key_rot_cw_alt = 8'h1A;  // also rotation + 1
	localparam logic [7:0] key_rot_ccw    = 8'h22;  // rotation - 1

endpackage

`default_nettype wire

/* design/tetris_pkg.sv */
`default_nettype none

package tetris_pkg;

	// ========================================
	// playfield geometry
	localparam int board_w   = 10;
	localparam int board_h   = 20;
	localparam int spawn_col = 4;

	typedef logic [board_w-1:0] row_t;        // bit c is column c
	typedef row_t [board_h-1:0] row_bus_t;    // element r is board row r, row 0 on top

	typedef enum logic [1:0] {
		st_idle,
		st_spawn,
		st_fall,
		st_place
	} game_state_t;

	// O, I, S, Z, L, J, T
	typedef logic [2:0] shape_t;
	typedef logic [1:0] rot_t;

	// bit 4*r + c is column c of piece row r
	typedef union packed {
		logic [15:0]     flat;
		logic [3:0][3:0] rows;
	} piece_mask_u;

	typedef struct packed {
		shape_t     shape;
		rot_t       rot;
		logic [5:0] col;   // leftmost mask column on the board
		logic [4:0] row;   // top mask row on the board
	} piece_t;

	// ========================================
	// shape table, rows written 3 down to 0
	function automatic piece_mask_u shape_mask(input shape_t shape, input rot_t rot);
		piece_mask_u m;
		case ({shape, rot})
			5'b000_00, 5'b000_01, 5'b000_10, 5'b000_11: m.flat = 16'b0000_0000_0011_0011;
			// I, two distinct orientations
			5'b001_00, 5'b001_10: m.flat = 16'b0000_0000_0000_1111;
			5'b001_01, 5'b001_11: m.flat = 16'b0001_0001_0001_0001;
			// S
			5'b010_00, 5'b010_10: m.flat = 16'b0000_0000_0011_0110;
			5'b010_01, 5'b010_11: m.flat = 16'b0000_0010_0011_0001;
			// Z
			5'b011_00, 5'b011_10: m.flat = 16'b0000_0000_0110_0011;
			5'b011_01, 5'b011_11: m.flat = 16'b0000_0001_0011_0010;
			// L
			5'b100_00: m.flat = 16'b0000_0000_0111_0100;
			5'b100_01: m.flat = 16'b0000_0010_0010_0011;
			5'b100_10: m.flat = 16'b0000_0000_0001_0111;
			5'b100_11: m.flat = 16'b0000_0011_0001_0001;
			// J
			5'b101_00: m.flat = 16'b0000_0000_0111_0001;
			5'b101_01: m.flat = 16'b0000_0011_0010_0010;
			5'b101_10: m.flat = 16'b0000_0000_0100_0111;
			5'b101_11: m.flat = 16'b0000_0001_0001_0011;
			// T
			5'b110_00: m.flat = 16'b0000_0000_0010_0111;
			5'b110_01: m.flat = 16'b0000_0001_0011_0001;
			5'b110_10: m.flat = 16'b0000_0000_0111_0010;
			5'b110_11: m.flat = 16'b0000_0010_0011_0010;
			default:   m.flat = 16'b0;  // shape 7 never comes out of the sequence
		endcase
		return m;
	endfunction

endpackage

`default_nettype wire

/* design/piece_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module piece_ctrl #(
	parameter int drop_div = 1_000_000
) (
	input  logic                    clk,
	input  logic                    rst,
	input  key_pkg::key_event_t     key,
	input  logic                    blocked,
	output tetris_pkg::game_state_t state,
	output tetris_pkg::row_bus_t    overlay,
	output logic                    place
);
	import tetris_pkg::*;
	import key_pkg::*;

	localparam int     cnt_w       = $clog2(drop_div);
	localparam shape_t first_shape = 3'd3;

	logic [cnt_w-1:0] tick_cnt;
	logic             tick;
	piece_t           piece;
	piece_mask_u      mask;
	logic [3:0]       used_cols;   // columns touched by any mask row
	logic [15:0]      right_span;
	logic             left_ok;
	logic             right_ok;
	logic             key_live;
	logic             show_piece;

	// ========================================
	// drop tick free running from reset
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + cnt_w'(1);
		end
	end

	assign tick = (tick_cnt == cnt_w'(drop_div - 1));

	// ========================================
	// game FSM
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (key.valid && key.code == key_start)
						state <= st_spawn;
				end
				st_spawn: begin
					if (tick)
						state <= st_fall;
				end
				st_fall: begin
					if (tick && blocked)
						state <= st_place;
				end
				st_place: state <= st_spawn;   // rows latch the piece on this edge
				default:  state <= st_idle;
			endcase
		end
	end

	assign place = (state == st_place);

	// ========================================
	// wall checks on the row view
	assign mask      = shape_mask(piece.shape, piece.rot);
	assign used_cols = mask.rows[0] | mask.rows[1] | mask.rows[2] | mask.rows[3];

	// only column 0 of the mask can leave the board on a left move
	assign left_ok    = (piece.col != 6'd0) || !used_cols[0];
	assign right_span = {12'b0, used_cols} << (piece.col + 6'd1);
	assign right_ok   = (right_span[15:board_w] == '0);

	assign key_live = key.valid && (state == st_fall);

	// ========================================
	// piece position, rotation and shape
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			piece.shape <= first_shape;
			piece.rot   <= '0;
			piece.col   <= 6'(spawn_col);
			piece.row   <= '0;
		end else if (state == st_spawn && tick) begin
			// 3 -> 6 -> 5 -> 3 ...
			piece.shape <= {piece.shape[1:0], piece.shape[1] ^ piece.shape[0]};
			piece.col   <= 6'(spawn_col);
			piece.row   <= '0;  // rotation carries over
		end else if (state == st_fall && tick) begin
			if (!blocked)
				piece.row <= piece.row + 5'd1;
		end else if (key_live) begin
			case (key.code)
				key_left: begin
					if (left_ok)
						piece.col <= piece.col - 6'd1;
				end
				key_right: begin
					if (right_ok)
						piece.col <= piece.col + 6'd1;
				end
				key_rot_cw, key_rot_cw_alt: piece.rot <= piece.rot + 2'd1;  // no fit check
				key_rot_ccw:                piece.rot <= piece.rot - 2'd1;
				default: ;
			endcase
		end
	end

	// ========================================
	// spread the mask over the board rows
	assign show_piece = (state == st_fall) || (state == st_place);

	always_comb begin
		overlay = '0;
		if (show_piece) begin
			for (int r = 0; r < 4; r++) begin
				for (int b = 0; b < board_h; b++) begin
					if (int'(piece.row) + r == b)
						overlay[b] = row_t'({6'b0, mask.rows[r]} << piece.col);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/board_row.sv */
`timescale 1ns/1ps
`default_nettype none

module board_row #(
	parameter bit last_row = 1'b0
) (
	input  logic             clk,
	input  logic             rst,
	input  tetris_pkg::row_t own_overlay,
	input  tetris_pkg::row_t above_overlay,
	input  logic             place,
	output logic             land_hit,
	output tetris_pkg::row_t view
);
	import tetris_pkg::*;

	row_t cells;      // settled cells of this row
	logic stack_hit;
	logic floor_hit;

	// ========================================
	// settled cells
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cells <= '0;
		end else if (place) begin
			cells <= cells | own_overlay;
		end
	end

	// piece one row up would drop into our cells
	assign stack_hit = (above_overlay & cells) != '0;

	// bottom row, piece already resting on the floor
	assign floor_hit = last_row && (own_overlay != '0);

	assign land_hit = stack_hit || floor_hit;
	assign view     = cells | own_overlay;

endmodule

`default_nettype wire

/* design/playfield_out.sv */
`timescale 1ns/1ps
`default_nettype none

module playfield_out (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [tetris_pkg::board_h-1:0] land_hits,
	input  tetris_pkg::row_bus_t          views,
	output logic                          blocked,
	output logic [4:0]                    scan_row,
	output tetris_pkg::row_t              scan_cells
);
	import tetris_pkg::*;

	logic [4:0] next_row;

	// any row refusing the next drop
	assign blocked = |land_hits;

	// ========================================
	// row scan
	assign next_row = (scan_row == 5'(board_h - 1)) ? 5'd0 : scan_row + 5'd1;

	// index and cells load on the same edge
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			scan_row   <= '0;
			scan_cells <= '0;
		end else begin
			scan_row   <= next_row;
			scan_cells <= views[next_row];
		end
	end

endmodule

`default_nettype wire

/* design/tetris_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_top #(
	parameter int drop_div = 1_000_000
) (
	input  logic                    clk,
	input  logic                    rst,
	input  key_pkg::key_event_t     key,
	output tetris_pkg::game_state_t state,
	output logic [4:0]              scan_row,
	output tetris_pkg::row_t        scan_cells
);
	import tetris_pkg::*;

	row_bus_t           overlay;
	row_bus_t           above;     // overlay of the row above, empty for row 0
	row_bus_t           views;
	logic [board_h-1:0] land_hits;
	logic               place;
	logic               blocked;

	piece_ctrl #(
		.drop_div (drop_div)
	) u_piece_ctrl (
		.clk     (clk),
		.rst     (rst),
		.key     (key),
		.blocked (blocked),
		.state   (state),
		.overlay (overlay),
		.place   (place)
	);

	assign above = {overlay[board_h-2:0], row_t'(0)};

	// ========================================
	// playfield rows
	for (genvar r = 0; r < board_h; r++) begin : g_row
		board_row #(
			.last_row (r == board_h - 1)
		) u_row (
			.clk           (clk),
			.rst           (rst),
			.own_overlay   (overlay[r]),
			.above_overlay (above[r]),
			.place         (place),
			.land_hit      (land_hits[r]),
			.view          (views[r])
		);
	end

	playfield_out u_playfield_out (
		.clk        (clk),
		.rst        (rst),
		.land_hits  (land_hits),
		.views      (views),
		.blocked    (blocked),
		.scan_row   (scan_row),
		.scan_cells (scan_cells)
	);

endmodule

`default_nettype wire

/* bench/tetris_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_assertions (
	input logic                    clk,
	input logic                    rst,
	input tetris_pkg::game_state_t state,
	input logic [4:0]              scan_row
);
	import tetris_pkg::*;

	// first edge after reset release
	a_idle_after_reset: assert property (
		@(posedge clk) $rose(rst) |-> state == st_idle
	) else $error("state not idle after reset release");

	a_scan_range: assert property (
		@(posedge clk) disable iff (!rst) scan_row <= 5'(board_h - 1)
	) else $error("scan_row beyond last board row");

	// scan wraps to the top row
	a_scan_wrap: assert property (
		@(posedge clk) disable iff (!rst)
		scan_row == 5'(board_h - 1) |=> scan_row == 5'd0
	) else $error("scan_row did not wrap to 0");

endmodule

`default_nettype wire

/* bench/tb_tetris.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tetris;
	import tetris_pkg::*;
	import key_pkg::*;

	// a full 20-row scan fits between two drop ticks
	localparam int drop_div = 32;
	localparam string stim_path = "bench/tetris_stim.txt";

	logic        clk;
	logic        rst;
	key_event_t  key;
	game_state_t state;
	logic [4:0]  scan_row;
	row_t        scan_cells;

	int    cyc;            // clk edges since reset release
	int    run_cycles;
	int    limit;
	int    state_errors;
	int    row_errors;
	int    other_errors;
	string test_name;

	string cmd_q [$];
	int    arg_q [$];
	string text_q [$];
	row_t  exp_q [$];

	tetris_top #(
		.drop_div (drop_div)
	) u_tetris_top (
		.clk        (clk),
		.rst        (rst),
		.key        (key),
		.state      (state),
		.scan_row   (scan_row),
		.scan_cells (scan_cells)
	);

	bind tetris_top tetris_assertions u_assertions (
		.clk      (clk),
		.rst      (rst),
		.state    (state),
		.scan_row (scan_row)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk or negedge rst) begin
		if (!rst)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	// ========================================
	// watchdog
	always @(posedge clk) begin
		run_cycles = run_cycles + 1;
		if (run_cycles > limit) begin
			$display("timeout: stimulus not finished after %0d cycles", limit);
			$display("errors: state %0d, row %0d, other %0d",
				state_errors, row_errors, other_errors + 1);
			$display("sim failed");
			$finish;
		end
	end

	// ========================================
	// compare tasks
	task automatic check_state(input game_state_t exp);
		if (state !== exp) begin
			$display("Mismatch %s state: expected %s actual %s", test_name, exp.name(),
				state.name());
			state_errors++;
		end
	endtask

	task automatic check_row(input int idx, input row_t exp, input row_t act);
		if (act !== exp) begin
			$display("Mismatch %s row %0d: expected %h actual %h", test_name, idx, exp, act);
			row_errors++;
		end
	endtask

	// ========================================
	// stimulus actions
	task automatic send_key(input logic [7:0] code);
		key.valid = 1'b1;
		key.code  = code;
		@(negedge clk);
		key = '0;
	endtask

	// stop on the falling edge right after the n-th following tick
	task automatic wait_ticks(input int n);
		int target;
		target = (cyc / drop_div + n) * drop_div;
		while (cyc != target)
			@(negedge clk);
	endtask

	task automatic capture_frame(input int base);
		row_t got [board_h];
		for (int k = 0; k < board_h; k++) begin
			@(negedge clk);
			got[scan_row] = scan_cells;
		end
		for (int r = 0; r < board_h; r++)
			check_row(r, exp_q[base + r], got[r]);
	endtask

	// ========================================
	// main sequence
	initial begin
		int    fd;
		int    n;
		int    val;
		int    ticks;
		int    base;
		string word;
		string text;
		string line;

		key          = '0;
		rst          = 1'b0;
		run_cycles   = 0;
		limit        = 100000;
		state_errors = 0;
		row_errors   = 0;
		other_errors = 0;
		test_name    = "unnamed";
		ticks        = 0;
		base         = 0;

		fd = $fopen(stim_path, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %s", stim_path);
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", word);
				if (n == 1) begin
					if (word.getc(0) == 8'h23) begin
						n = $fgets(line, fd);   // comment line
					end else if (word == "name") begin
						n = $fscanf(fd, "%s", text);
						cmd_q.push_back(word);
						arg_q.push_back(0);
						text_q.push_back(text);
					end else if (word == "key" || word == "wait" || word == "state") begin
						if (word == "key")
							n = $fscanf(fd, "%h", val);
						else
							n = $fscanf(fd, "%d", val);
						if (word == "wait")
							ticks += val;
						cmd_q.push_back(word);
						arg_q.push_back(val);
						text_q.push_back("");
					end else if (word == "frame") begin
						for (int r = 0; r < board_h; r++) begin
							n = $fscanf(fd, "%h", val);
							exp_q.push_back(row_t'(val));
						end
						cmd_q.push_back(word);
						arg_q.push_back(0);
						text_q.push_back("");
					end else begin
						$display("unknown command %s in stimulus file", word);
						other_errors++;
					end
				end
			end
			$fclose(fd);
		end
		limit = ticks * drop_div + 200;

		repeat (3) @(negedge clk);
		rst = 1'b1;

		foreach (cmd_q[i]) begin
			if (cmd_q[i] == "name") begin
				test_name = text_q[i];
			end else if (cmd_q[i] == "key") begin
				send_key(8'(arg_q[i]));
			end else if (cmd_q[i] == "wait") begin
				wait_ticks(arg_q[i]);
			end else if (cmd_q[i] == "state") begin
				check_state(game_state_t'(2'(arg_q[i])));
			end else begin
				capture_frame(base);
				base += board_h;
			end
		end

		$display("errors: state %0d, row %0d, other %0d", state_errors, row_errors,
			other_errors);
		if (state_errors + row_errors + other_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tetris_stim.txt */
# commands: name <label>, key <hex scan code>, wait <ticks>, state <0 idle 1 spawn 2 fall 3 place>
# frame: 20 hex row values follow, row 0 first, bit c is column c
name reset_idle
state 0
frame
000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000
key 6b
state 0
wait 1
name start_spawn
key 5a
state 1
wait 1
name first_piece_t
state 2
frame
070 020 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000
name drop_one
wait 1
frame
000 070 020 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000
wait 1
name move_left
key 6b
frame
000 000 038 010 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000
wait 1
name move_right
key 74
key 74
frame
000 000 000 0e0 040 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000
wait 1
name right_wall
key 74
key 74
key 74
frame
000 000 000 000 380 100 000 000 000 000
000 000 000 000 000 000 000 000 000 000
wait 1
name rotate_cw
key 12
frame
000 000 000 000 000 080 180 080 000 000
000 000 000 000 000 000 000 000 000 000
wait 1
name rotate_ccw
key 22
frame
000 000 000 000 000 000 380 100 000 000
000 000 000 000 000 000 000 000 000 000
wait 1
name left_wall
key 6b
key 6b
key 6b
key 6b
key 6b
key 6b
key 6b
key 6b
frame
000 000 000 000 000 000 000 007 002 000
000 000 000 000 000 000 000 000 000 000
name floor_reach
wait 11
state 2
frame
000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 007 002
name floor_place
wait 1
state 3
frame
000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 007 002
state 1
name second_piece_j
wait 1
state 2
frame
010 070 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 007 002
name j_left_wall
wait 1
key 6b
key 6b
key 6b
key 6b
key 6b
frame
000 001 007 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 007 002
name stack_reach
wait 15
state 2
frame
000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 001 007 007 002
name stack_place
wait 1
state 3
frame
000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 001 007 007 002
state 1
name third_piece_z
wait 1
state 2
frame
030 060 000 000 000 000 000 000 000 000
000 000 000 000 000 000 001 007 007 002

/* vlog.f */
design/key_pkg.sv
design/tetris_pkg.sv
design/piece_ctrl.sv
design/board_row.sv
design/playfield_out.sv
design/tetris_top.sv
bench/tetris_assertions.sv
bench/tb_tetris.sv

/* run.sh */
#!/bin/sh
# build and run the tetris testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_tetris -f vlog.f -o tb_tetris_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

out=$(./obj_dir/tb_tetris_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
	exit 0
else
	echo "pass line not found in simulation output"
	exit 1
fi
